/* Bender.yml */
package:
  name: mips_decoder

sources:
  - rtl/mips_isa_pkg.sv
  - rtl/mips_exec_pkg.sv
  - rtl/mips_regfile.sv
  - rtl/mips_alu.sv
  - rtl/instr_accept.sv
  - rtl/exec_core.sv
  - rtl/result_port.sv
  - rtl/mips_decoder_top.sv
  - target: test
    files:
      - verif/tb_mips_decoder.sv

/* mips_decoder.f */
rtl/mips_isa_pkg.sv
rtl/mips_exec_pkg.sv
rtl/mips_regfile.sv
rtl/mips_alu.sv
rtl/instr_accept.sv
rtl/exec_core.sv
rtl/result_port.sv
rtl/mips_decoder_top.sv
verif/tb_mips_decoder.sv

/* rtl/exec_core.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_core import mips_isa_pkg::*, mips_exec_pkg::*;
(
	input  wire      clk,
	input  wire      reset,
	input  wire      instr_valid,
	input  alu_op_t  op,
	input  reg_idx_t rs,
	input  reg_idx_t rt,
	input  reg_idx_t rd_sel,
	input  imm_t     imm,
	input  shamt_t   shamt,
	input  wire      use_imm,
	input  wire      write_en,
	output logic     result_valid,
	output word_t    result
);

	exec_state_t state;
	word_t       s;
	word_t       t;
	word_t       d;
	word_t       rd_data_a;
	word_t       rd_data_b;
	word_t       imm_ext;
	word_t       alu_y;

	// addi immediate is sign extended
	assign imm_ext = {{($bits(word_t)-$bits(imm_t)){imm[$bits(imm_t)-1]}}, imm};

	mips_regfile u_regfile (
		.clk       (clk),
		.reset     (reset),
		.rd_addr_a (rs),
		.rd_addr_b (rt),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wr_en     (state == EX_WRITE && write_en),
		.wr_addr   (rd_sel),
		.wr_data   (d)
	);

	mips_alu u_alu (
		.op    (op),
		.a     (s),
		.b     (t),
		.shamt (shamt),
		.y     (alu_y)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= EX_IDLE;
		else
		begin
			case (state)
				EX_IDLE:  if (instr_valid) state <= EX_FETCH;
				EX_FETCH: state <= EX_EXEC;
				EX_EXEC:  state <= EX_WRITE;
				EX_WRITE: state <= EX_IDLE;
				default:  state <= EX_IDLE;
			endcase
		end
	end

	// operand and result registers
	always_ff @(posedge clk)
	begin
		if (state == EX_FETCH)
		begin
			s <= rd_data_a;
			t <= use_imm ? imm_ext : rd_data_b;
		end
		if (state == EX_EXEC)
			d <= alu_y;
	end

	// register write and hand-off share the edge that ends EX_WRITE
	assign result_valid = (state == EX_WRITE);
	assign result       = d;

	a_fixed_latency: assert property (@(posedge clk) disable iff (reset)
		instr_valid |-> ##3 result_valid);

endmodule

`default_nettype wire

/* rtl/instr_accept.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_accept import mips_isa_pkg::*, mips_exec_pkg::*;
(
	input  wire     clk,
	input  wire     reset,
	input  wire     dir,
	input  instr_t  data_in,
	input  wire     result_taken,
	output logic    ack_prev,
	output logic    instr_valid,
	output alu_op_t op,
	output reg_idx_t rs,
	output reg_idx_t rt,
	output reg_idx_t rd_sel,
	output imm_t    imm,
	output shamt_t  shamt,
	output logic    use_imm,
	output logic    write_en
);

	logic     busy;
	opcode_t  opcode;
	funct_t   funct;
	alu_op_t  dec_op;
	logic     dec_use_imm;
	logic     dec_write_en;

	assign opcode = data_in[OPC_LSB +: $bits(opcode_t)];
	assign funct  = data_in[FUNCT_LSB +: $bits(funct_t)];

	// accept strobe while idle
	assign instr_valid = dir && !busy;

	always_comb
	begin
		dec_op       = OP_NONE;
		dec_use_imm  = 1'b0;
		dec_write_en = 1'b0;
		if (opcode == OPC_SPECIAL)
		begin
			dec_write_en = 1'b1;
			case (funct)
				FN_SLL:  dec_op = OP_SLL;
				FN_SRL:  dec_op = OP_SRL;
				FN_SRA:  dec_op = OP_SRA;
				FN_ADD, FN_ADDU: dec_op = OP_ADD;
				FN_SUB, FN_SUBU: dec_op = OP_SUB;
				FN_AND:  dec_op = OP_AND;
				FN_OR:   dec_op = OP_OR;
				FN_XOR:  dec_op = OP_XOR;
				FN_NOR:  dec_op = OP_NOR;
				FN_SLT:  dec_op = OP_SLT;
				default:
				begin
					dec_op       = OP_NONE;
					dec_write_en = 1'b0; // unknown funct writes nothing
				end
			endcase
		end
		else if (opcode == OPC_ADDI)
		begin
			dec_op       = OP_ADD;
			dec_use_imm  = 1'b1;
			dec_write_en = 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy     <= 1'b0;
			ack_prev <= 1'b0;
		end
		else
		begin
			ack_prev <= instr_valid; // single cycle after accept
			if (instr_valid)
				busy <= 1'b1;
			else if (result_taken)
				busy <= 1'b0;
		end
	end

	// decoded fields stay put until the next accept
	always_ff @(posedge clk)
	begin
		if (instr_valid)
		begin
			op       <= dec_op;
			rs       <= data_in[RS_LSB +: $bits(reg_idx_t)];
			rt       <= data_in[RT_LSB +: $bits(reg_idx_t)];
			// addi writes its rt field
			rd_sel   <= dec_use_imm ? data_in[RT_LSB +: $bits(reg_idx_t)]
			                        : data_in[RD_LSB +: $bits(reg_idx_t)];
			imm      <= data_in[IMM_LSB +: $bits(imm_t)];
			shamt    <= data_in[SHAMT_LSB +: $bits(shamt_t)];
			use_imm  <= dec_use_imm;
			write_en <= dec_write_en;
		end
	end

	// output side only hands back the instruction in flight
	a_taken_while_busy: assert property (@(posedge clk) disable iff (reset)
		result_taken |-> busy);

endmodule

`default_nettype wire

/* rtl/mips_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_alu import mips_isa_pkg::*, mips_exec_pkg::*;
(
	input  alu_op_t op,
	input  word_t   a,
	input  word_t   b,
	input  shamt_t  shamt,
	output word_t   y
);

	logic signed [$bits(word_t)-1:0] a_s;
	logic signed [$bits(word_t)-1:0] b_s;

	assign a_s = a;
	assign b_s = b;

	always_comb
	begin
		case (op)
			// shifts operate on the T operand
			OP_SLL: y = b << shamt;
			OP_SRL: y = b >> shamt;
			OP_SRA: y = word_t'(b_s >>> shamt); // sign fill
			// both wrap around, no trap
			OP_ADD: y = a + b;
			OP_SUB: y = a - b;
			OP_AND: y = a & b;
			OP_OR:  y = a | b;
			OP_XOR: y = a ^ b;
			OP_NOR: y = ~(a | b);
			OP_SLT:
			begin
				// signed compare
				if (a_s < b_s)
					y = word_t'(1);
				else
					y = '0;
			end
			default: y = '0; // OP_NONE
		endcase
	end

endmodule

`default_nettype wire

/* rtl/mips_decoder_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_decoder_top import mips_isa_pkg::*, mips_exec_pkg::*;
(
	input  wire    clk,
	input  wire    reset,
	input  wire    dir,
	input  instr_t data_in,
	input  wire    ack_from_next,
	output logic   ack_prev,
	output logic   dor,
	output word_t  data_out
);

	logic     instr_valid;
	alu_op_t  op;
	reg_idx_t rs;
	reg_idx_t rt;
	reg_idx_t rd_sel;
	imm_t     imm;
	shamt_t   shamt;
	logic     use_imm;
	logic     write_en;
	logic     result_valid;
	word_t    result;
	logic     result_taken;

	instr_accept u_accept (
		.clk          (clk),
		.reset        (reset),
		.dir          (dir),
		.data_in      (data_in),
		.result_taken (result_taken),
		.ack_prev     (ack_prev),
		.instr_valid  (instr_valid),
		.op           (op),
		.rs           (rs),
		.rt           (rt),
		.rd_sel       (rd_sel),
		.imm          (imm),
		.shamt        (shamt),
		.use_imm      (use_imm),
		.write_en     (write_en)
	);

	exec_core u_core (
		.clk          (clk),
		.reset        (reset),
		.instr_valid  (instr_valid),
		.op           (op),
		.rs           (rs),
		.rt           (rt),
		.rd_sel       (rd_sel),
		.imm          (imm),
		.shamt        (shamt),
		.use_imm      (use_imm),
		.write_en     (write_en),
		.result_valid (result_valid),
		.result       (result)
	);

	result_port u_result (
		.clk           (clk),
		.reset         (reset),
		.result_valid  (result_valid),
		.result        (result),
		.ack_from_next (ack_from_next),
		.dor           (dor),
		.data_out      (data_out),
		.result_taken  (result_taken)
	);

endmodule

`default_nettype wire

/* rtl/mips_exec_pkg.sv */
`default_nettype none

// datapath widths and sequencing states of the executer
package mips_exec_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;

	localparam reg_idx_t REG_ZERO = 5'd0; // hardwired zero
	localparam int       NUM_REGS = 32;

	// one instruction in flight, fixed three steps
	typedef enum logic [1:0] {
		EX_IDLE,
		EX_FETCH, // read S and T
		EX_EXEC,  // compute D
		EX_WRITE  // write back, hand result on
	} exec_state_t;

endpackage

`default_nettype wire

/* rtl/mips_isa_pkg.sv */
`default_nettype none

// MIPS32 instruction word layout and the subset of codes handled here
package mips_isa_pkg;

	typedef logic [31:0] instr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [4:0]  shamt_t;
	typedef logic [15:0] imm_t;

	// lsb of each field in the instruction word
	localparam int OPC_LSB   = 26;
	localparam int RS_LSB    = 21;
	localparam int RT_LSB    = 16;
	localparam int RD_LSB    = 11;
	localparam int SHAMT_LSB = 6;
	localparam int FUNCT_LSB = 0;
	localparam int IMM_LSB   = 0;

	// major opcodes
	localparam opcode_t OPC_SPECIAL = 6'h00; // all R-type
	localparam opcode_t OPC_ADDI    = 6'h08;

	// R-type function codes
	localparam funct_t FN_SLL  = 6'h00;
	localparam funct_t FN_SRL  = 6'h02;
	localparam funct_t FN_SRA  = 6'h03;
	localparam funct_t FN_ADD  = 6'h20;
	localparam funct_t FN_ADDU = 6'h21;
	localparam funct_t FN_SUB  = 6'h22;
	localparam funct_t FN_SUBU = 6'h23;
	localparam funct_t FN_AND  = 6'h24;
	localparam funct_t FN_OR   = 6'h25;
	localparam funct_t FN_XOR  = 6'h26;
	localparam funct_t FN_NOR  = 6'h27;
	localparam funct_t FN_SLT  = 6'h2A;

	// add/addu and sub/subu share one operation, no overflow trap
	typedef enum logic [3:0] {
		OP_SLL,
		OP_SRL,
		OP_SRA,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_NOR,
		OP_SLT,
		OP_NONE
	} alu_op_t;

endpackage

`default_nettype wire

/* rtl/mips_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_regfile import mips_exec_pkg::*;
(
	input  wire      clk,
	input  wire      reset,
	input  reg_idx_t rd_addr_a,
	input  reg_idx_t rd_addr_b,
	output word_t    rd_data_a,
	output word_t    rd_data_b,
	input  wire      wr_en,
	input  reg_idx_t wr_addr,
	input  word_t    wr_data
);

	// $1..$31, $0 is not stored
	word_t regs [1:NUM_REGS-1];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 1; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (wr_en && wr_addr != REG_ZERO)
		begin
			regs[wr_addr] <= wr_data;
		end
	end

	// asynchronous reads
	always_comb
	begin
		if (rd_addr_a == REG_ZERO)
			rd_data_a = '0;
		else
			rd_data_a = regs[rd_addr_a];
	end

	always_comb
	begin
		if (rd_addr_b == REG_ZERO)
			rd_data_b = '0;
		else
			rd_data_b = regs[rd_addr_b];
	end

endmodule

`default_nettype wire

/* rtl/result_port.sv */
`timescale 1ns/1ns
`default_nettype none

module result_port import mips_exec_pkg::*;
(
	input  wire   clk,
	input  wire   reset,
	input  wire   result_valid,
	input  word_t result,
	input  wire   ack_from_next,
	output logic  dor,
	output word_t data_out,
	output logic  result_taken
);

	// next stage took the word at this edge
	assign result_taken = dor && ack_from_next;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			dor      <= 1'b0;
			data_out <= '0;
		end
		else if (result_valid)
		begin
			dor      <= 1'b1;
			data_out <= result;
		end
		else if (result_taken)
		begin
			dor <= 1'b0; // data_out keeps the last value
		end
	end

	// back-pressure holds the word and the level
	a_hold_under_stall: assert property (@(posedge clk) disable iff (reset)
		dor && !ack_from_next |=> dor && $stable(data_out));

endmodule

`default_nettype wire

/* verif/tb_mips_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mips_decoder import mips_isa_pkg::*, mips_exec_pkg::*;
();

	localparam int ACK_TIMEOUT = 20; // cycles
	localparam int DOR_TIMEOUT = 20;

	logic   clk;
	logic   reset;
	logic   dir;
	instr_t data_in;
	logic   ack_from_next;
	logic   ack_prev;
	logic   dor;
	word_t  data_out;

	int     seed = 64570;
	int     errors = 0;
	int     n_tests = 0;
	int     n_failed = 0;
	int     test_err_start = 0;
	bit     timed_out = 1'b0;
	logic   outstanding;
	word_t  exp_result = '0;
	word_t  shadow [0:NUM_REGS-1]; // register model
	funct_t alu_fns [0:8] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR,
		FN_NOR, FN_SLT};
	funct_t shift_fns [0:2] = '{FN_SLL, FN_SRL, FN_SRA};

	mips_decoder_top DUT (
		.clk           (clk),
		.reset         (reset),
		.dir           (dir),
		.data_in       (data_in),
		.ack_from_next (ack_from_next),
		.ack_prev      (ack_prev),
		.dor           (dor),
		.data_out      (data_out)
	);

	always #10 clk = ~clk;

	// accepted, not yet taken by the next stage
	always @(posedge clk)
	begin
		if (reset)
			outstanding <= 1'b0;
		else if (ack_prev)
			outstanding <= 1'b1;
		else if (dor && ack_from_next)
			outstanding <= 1'b0;
	end

	a_result_value: assert property (@(posedge clk) disable iff (reset)
		$rose(dor) |-> data_out == exp_result)
	else
	begin
		$display("[ERROR] %0t data_out expected %h got %h", $time, exp_result, data_out);
		errors++;
	end

	a_ack_width: assert property (@(posedge clk) disable iff (reset) ack_prev |=> !ack_prev)
	else
	begin
		$display("[ERROR] %0t ack_prev expected 0 got 1", $time);
		errors++;
	end

	// accepting edge is one cycle before ack_prev is seen
	a_dor_latency: assert property (@(posedge clk) disable iff (reset)
		ack_prev |-> !dor ##1 !dor ##1 !dor ##1 dor)
	else
	begin
		$display("%0t dor did not rise 3 cycles after the accepting edge", $time);
		errors++;
	end

	a_hold: assert property (@(posedge clk) disable iff (reset)
		dor && !ack_from_next |=> dor && data_out == $past(data_out))
	else
	begin
		$display("%0t dor or data_out changed while ack_from_next was low", $time);
		errors++;
	end

	a_one_in_flight: assert property (@(posedge clk) disable iff (reset)
		ack_prev |-> !outstanding)
	else
	begin
		$display("%0t a second ack_prev came before dor fell", $time);
		errors++;
	end

	function automatic word_t rand_word();
		return $random(seed);
	endfunction

	function automatic reg_idx_t rand_reg(); // 1..31
		word_t v;
		v = rand_word();
		return reg_idx_t'(v % 31 + 1);
	endfunction

	function automatic int rand_delay();
		word_t v;
		v = rand_word();
		return int'(v % 6);
	endfunction

	function automatic instr_t rtype(input funct_t fn, input reg_idx_t rd, input reg_idx_t rs,
		input reg_idx_t rt, input shamt_t sh);
		return {OPC_SPECIAL, rs, rt, rd, sh, fn};
	endfunction

	function automatic instr_t addi_word(input reg_idx_t rt, input reg_idx_t rs, input imm_t imm);
		return {OPC_ADDI, rs, rt, imm};
	endfunction

	// expected result, write flag and destination from the shadow registers
	function automatic void model_exec(input instr_t w, output word_t res, output bit wr,
		output reg_idx_t dst);
		word_t  a;
		word_t  b;
		shamt_t sh;
		a   = shadow[w[25:21]];
		b   = shadow[w[20:16]];
		sh  = w[10:6];
		res = '0;
		wr  = 1'b1;
		dst = w[15:11];
		if (w[31:26] == OPC_ADDI)
		begin
			dst = w[20:16];
			res = a + {{16{w[15]}}, w[15:0]};
		end
		else if (w[31:26] == OPC_SPECIAL)
		begin
			case (w[5:0])
				FN_SLL: res = b << sh;
				FN_SRL: res = b >> sh;
				FN_SRA:
				begin
					res = b >> sh;
					if (b[31])
						res = res | ~(32'hffff_ffff >> sh); // fill vacated bits
				end
				FN_ADD, FN_ADDU: res = a + b;
				FN_SUB, FN_SUBU: res = a - b;
				FN_AND: res = a & b;
				FN_OR:  res = a | b;
				FN_XOR: res = a ^ b;
				FN_NOR: res = ~(a | b);
				FN_SLT: res = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
				default: wr = 1'b0;
			endcase
		end
		else
			wr = 1'b0;
	endfunction

	// called on a falling edge, returns on a falling edge
	task automatic send_instr(input instr_t word, input word_t expected, input int delay,
		input bit keep_dir);
		int cnt;
		cnt = 0;
		if (!timed_out)
		begin
			exp_result = expected;
			data_in    = word;
			dir        = 1'b1;
			@(negedge clk);
			while (!ack_prev && cnt < ACK_TIMEOUT)
			begin
				@(negedge clk);
				cnt++;
			end
			if (!ack_prev)
			begin
				$display("%0t timeout, instruction %h was never acknowledged", $time, word);
				errors++;
				timed_out = 1'b1;
				dir       = 1'b0;
			end
			else
			begin
				if (!keep_dir)
					dir = 1'b0;
				cnt = 0;
				while (!dor && cnt < DOR_TIMEOUT)
				begin
					@(negedge clk);
					cnt++;
				end
				if (!dor)
				begin
					$display("%0t timeout, no result for instruction %h", $time, word);
					errors++;
					timed_out = 1'b1;
				end
				else
				begin
					repeat (delay) @(negedge clk); // back-pressure
					ack_from_next = 1'b1;
					@(negedge clk);
					ack_from_next = 1'b0;
					assert (dor == 1'b0)
					else
					begin
						$display("[ERROR] %0t dor expected 0 got %b", $time, dor);
						errors++;
					end
				end
			end
		end
	endtask

	task automatic run_instr(input instr_t word, input int delay, input bit keep_dir);
		word_t    res;
		bit       wr;
		reg_idx_t dst;
		model_exec(word, res, wr, dst);
		send_instr(word, res, delay, keep_dir);
		if (wr && dst != REG_ZERO)
			shadow[dst] = res;
	endtask

	task automatic issue(input instr_t word);
		run_instr(word, rand_delay(), 1'b0);
	endtask

	// full 32-bit random value, tmp is overwritten
	task automatic load_word(input reg_idx_t r, input reg_idx_t tmp);
		word_t v;
		v = rand_word();
		issue(addi_word(tmp, REG_ZERO, v[15:0]));
		issue(addi_word(r, REG_ZERO, v[31:16]));
		issue(rtype(FN_SLL, r, REG_ZERO, r, 5'd16));
		issue(rtype(FN_XOR, r, r, tmp, 5'd0));
	endtask

	task automatic end_test(input string name);
		n_tests++;
		if (errors != test_err_start)
		begin
			n_failed++;
			$display("test %0d %s: FAIL, %0d errors", n_tests, name, errors - test_err_start);
		end
		else
			$display("test %0d %s: ok", n_tests, name);
		test_err_start = errors;
	endtask

	initial
	begin
		instr_t w;
		word_t  v;
		clk           = 1'b0;
		reset         = 1'b1;
		dir           = 1'b0;
		data_in       = '0;
		ack_from_next = 1'b0;
		for (int i = 0; i < NUM_REGS; i++)
			shadow[i] = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		assert (dor == 1'b0 && ack_prev == 1'b0 && data_out == '0)
		else
		begin
			$display("[ERROR] %0t dor/ack_prev/data_out expected 0/0/0 got %b/%b/%h",
				$time, dor, ack_prev, data_out);
			errors++;
		end
		issue(rtype(FN_ADD, 5'd3, 5'd1, 5'd2, 5'd0)); // unwritten registers
		end_test("reset_state");

		for (int i = 1; i < NUM_REGS; i++)
		begin
			v = rand_word();
			issue(addi_word(reg_idx_t'(i), rand_reg(), v[15:0]));
		end
		issue(addi_word(5'd4, 5'd4, 16'h8000)); // most negative immediate
		end_test("addi_load");

		for (int i = 2; i < 12; i++)
			load_word(reg_idx_t'(i), 5'd1);
		for (int i = 0; i < 60; i++)
			issue(rtype(alu_fns[rand_word() % 9], rand_reg(), rand_reg(), rand_reg(), 5'd0));
		issue(addi_word(5'd12, REG_ZERO, 16'h0007));
		issue(addi_word(5'd13, REG_ZERO, 16'hfff0));
		issue(rtype(FN_SLT, 5'd14, 5'd12, 5'd13, 5'd0)); // positive vs negative
		issue(rtype(FN_SLT, 5'd14, 5'd13, 5'd12, 5'd0));
		end_test("alu_ops");

		issue(addi_word(5'd20, REG_ZERO, 16'h8001));
		issue(rtype(FN_SRA, 5'd21, REG_ZERO, 5'd20, 5'd31));
		for (int i = 0; i < 30; i++)
		begin
			v = rand_word();
			issue(rtype(shift_fns[v % 3], rand_reg(), REG_ZERO, rand_reg(), v[10:6]));
		end
		end_test("shifts");

		issue(addi_word(REG_ZERO, REG_ZERO, 16'h1234)); // result shown, not stored
		issue(rtype(FN_OR, 5'd6, REG_ZERO, REG_ZERO, 5'd0));
		w        = rand_word();
		w[31:26] = 6'h23; // load opcode, not handled
		issue(w);
		issue(rtype(6'h08, 5'd7, 5'd2, 5'd3, 5'd0));
		for (int i = 1; i < NUM_REGS; i++)
			issue(rtype(FN_ADD, REG_ZERO, reg_idx_t'(i), REG_ZERO, 5'd0));
		end_test("zero_reg_unknown");

		// dir stays high while busy
		run_instr(rtype(FN_ADD, 5'd8, 5'd2, 5'd3, 5'd0), 8, 1'b1);
		run_instr(rtype(FN_SUB, 5'd9, 5'd8, 5'd4, 5'd0), 8, 1'b1);
		run_instr(rtype(FN_XOR, 5'd10, 5'd9, 5'd8, 5'd0), 0, 1'b0);
		end_test("handshake");

		$display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, errors);
		if (errors == 0 && !timed_out)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire
